//--- run_sim.sh
#!/bin/sh
# builds the fetch subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f src.f \
	--top-module tb_fetch_subsys \
	-Mdir obj_dir -o sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# a high error limit lets a failing assertion reach the final verdict
output=$(./obj_dir/sim +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
echo "simulation did not report a clean run"
exit 1

//--- src.f
src/bus_pkg.sv
src/fetch_pkg.sv
src/fetch_frontend.sv
src/mem_arbiter.sv
src/load_store_unit.sv
src/sram_model.sv
src/fetch_subsys_top.sv
verification/fetch_subsys_chk.sv
verification/tb_fetch_subsys.sv

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// ==================================================
	// shared memory bus widths
	// ==================================================

	// byte address, the low two bits only matter to the fetch side
	typedef logic [31:0] addr_t;

	// one bus data word, always transferred whole
	typedef logic [31:0] word_t;

	// a single 16-bit instruction parcel
	typedef logic [15:0] half_t;

	// which peer a data phase returns to
	typedef enum logic {
		owner_fetch,
		owner_ls
	} owner_t;

endpackage

`default_nettype wire

//--- src/fetch_frontend.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_frontend #(
	parameter int FIFO_DEPTH  = 2,
	parameter bit EXTENSION_C = 1'b1
) (
	input  wire                        clk,
	input  wire                        rst_n,
	// fetch master side of the bus, size high means a full word
	output bus_pkg::addr_t             mem_addr,
	output logic                       mem_size,
	output logic                       mem_addr_vld,
	input  wire                        mem_addr_rdy,
	input  wire bus_pkg::word_t        mem_data,
	input  wire                        mem_data_vld,
	// jump and flush requests from the core
	input  wire bus_pkg::addr_t        jump_target,
	input  wire                        jump_target_vld,
	output logic                       jump_target_rdy,
	// decode side
	output bus_pkg::word_t             cir,
	output fetch_pkg::cir_level_t      cir_vld,
	input  wire fetch_pkg::cir_level_t cir_use,
	input  wire                        cir_lock
);
	import bus_pkg::*;
	import fetch_pkg::*;

// thermometer pattern of the queue one entry short of full
localparam logic [FIFO_DEPTH-1:0] ALMOST_FULL = FIFO_DEPTH'((1 << (FIFO_DEPTH - 1)) - 1);

// ==================================================
// prefetch queue
// ==================================================

logic                  jump_now;
word_t                 fifo_mem [FIFO_DEPTH];
logic [FIFO_DEPTH-1:0] fifo_valid;
logic                  fifo_full;
logic                  fifo_empty;
logic                  fifo_almost_full;
logic                  fifo_push;
logic                  fifo_pop;

assign jump_now         = jump_target_vld && jump_target_rdy;
assign fifo_full        = fifo_valid[FIFO_DEPTH-1];
assign fifo_empty       = !fifo_valid[0];
assign fifo_almost_full = fifo_valid == ALMOST_FULL;

// valid bits form a thermometer code, entry 0 is the head
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		fifo_valid <= '0;
	end else if (jump_now) begin
		fifo_valid <= '0;
	end else if (fifo_push || fifo_pop) begin
		fifo_valid <= ~(~fifo_valid << fifo_push) >> fifo_pop;
	end
end

// each entry takes its upper neighbour on a pop, or fresh bus data
// when it is the first free slot
for (genvar i = 0; i < FIFO_DEPTH; i++) begin : g_fifo
	word_t shift_in;
	if (i == FIFO_DEPTH - 1) begin : g_tail
		assign shift_in = mem_data;
	end else begin : g_body
		assign shift_in = fifo_valid[i + 1] ? fifo_mem[i + 1] : mem_data;
	end
	always_ff @(posedge clk) begin
		if (fifo_pop || (fifo_push && !fifo_valid[i])) begin
			fifo_mem[i] <= shift_in;
		end
	end
end

// ==================================================
// fetch address generation
// ==================================================

logic       mem_addr_hold;
logic [1:0] pending_fetches;
logic [1:0] flush_count;
logic       cir_must_refill;
addr_t      fetch_addr;
logic       fetch_stall;
logic       addr_req;
logic       reset_holdoff;

// data that goes straight into cir is not written to the queue as well
assign fifo_push = mem_data_vld && flush_count == 2'd0 && !(cir_must_refill && fifo_empty);

// a request is counted the first cycle it is offered, and stays counted
// while it is held; flush_count is how many returns belong to an old stream
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		mem_addr_hold   <= 1'b0;
		pending_fetches <= 2'd0;
		flush_count     <= 2'd0;
	end else begin
		mem_addr_hold   <= mem_addr_vld && !mem_addr_rdy;
		pending_fetches <= pending_fetches + 2'(mem_addr_vld && !mem_addr_hold)
			- 2'(mem_data_vld);
		if (jump_now) begin
			flush_count <= pending_fetches - 2'(mem_data_vld);
		end else if (flush_count != 2'd0 && mem_data_vld) begin
			flush_count <= flush_count - 2'd1;
		end
	end
end

// runs ahead of decode in whole words
// a jump that is accepted on the bus at once moves straight to the next word
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		fetch_addr <= RESET_VECTOR;
	end else if (jump_now) begin
		fetch_addr <= {jump_target[31:2] + 30'(mem_addr_rdy), 2'b00};
	end else if (mem_addr_vld && mem_addr_rdy) begin
		fetch_addr <= fetch_addr + 32'd4;
	end
end

// stop on a full queue, and do not let two fetches race for the last slot
assign fetch_stall = fifo_full
	|| (fifo_almost_full && pending_fetches != 2'd0)
	|| pending_fetches > 2'd1;

// an odd-halfword target is seen twice: in the address phase if the bus
// stalled the jump, and in the data phase where cir takes the upper half only
logic unaligned_jump_now;
logic unaligned_jump_aph;
logic unaligned_jump_dph;

assign unaligned_jump_now = EXTENSION_C && jump_now && jump_target[1];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		unaligned_jump_aph <= 1'b0;
		unaligned_jump_dph <= 1'b0;
	end else if (EXTENSION_C) begin
		if (mem_addr_rdy || (jump_now && !unaligned_jump_now)) begin
			unaligned_jump_aph <= 1'b0;
		end
		// after a locked cir the odd word may be waiting in the queue instead
		if ((mem_data_vld && flush_count == 2'd0 && !cir_lock)
			|| (jump_now && !unaligned_jump_now) || fifo_pop) begin
			unaligned_jump_dph <= 1'b0;
		end
		if (unaligned_jump_now) begin
			unaligned_jump_dph <= 1'b1;
			unaligned_jump_aph <= !mem_addr_rdy;
		end
	end
end

// the bus sees no request in the first cycle out of reset
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		reset_holdoff <= 1'b1;
	end else begin
		reset_holdoff <= 1'b0;
	end
end

// priority is a held request, then a jump, then sequential prefetch
always_comb begin
	mem_addr = fetch_addr;
	mem_size = 1'b1;
	addr_req = 1'b1;
	if (mem_addr_hold) begin
		mem_addr = {fetch_addr[31:2], unaligned_jump_aph, 1'b0};
		mem_size = !unaligned_jump_aph;
	end else if (jump_target_vld) begin
		mem_addr = jump_target;
		mem_size = !unaligned_jump_now;
	end else if (fetch_stall) begin
		addr_req = 1'b0;
	end
end

assign mem_addr_vld    = addr_req && !reset_holdoff;
assign jump_target_rdy = !mem_addr_hold && !reset_holdoff;

// ==================================================
// instruction assembly yard
// ==================================================

// buf_level counts valid halfwords in {hwbuf, cir}, 3 at most
logic [1:0] buf_level;
half_t      hwbuf;
word_t      fetch_data;
logic       fetch_data_vld;
logic [47:0] instr_shifted;
logic [47:0] instr_next;
cir_level_t cir_use_clipped;
logic [1:0] level_no_fetch;
logic [1:0] buf_level_next;

// bus data bypasses an empty queue
assign fetch_data     = fifo_empty ? mem_data : fifo_mem[0];
assign fetch_data_vld = !fifo_empty || (mem_data_vld && flush_count == 2'd0);

// after a lock is released buf_level is 0 while decode may still consume
assign cir_use_clipped = buf_level != 2'd0 ? cir_use : 2'd0;
assign level_no_fetch  = buf_level - cir_use_clipped;

// move leftover halfwords down by what decode took; slots that will be
// overwritten or are invalid get whatever is cheapest
always_comb begin
	if (cir_use[1]) begin
		instr_shifted = {hwbuf, cir[31:16], hwbuf};
	end else if (cir_use[0] && EXTENSION_C) begin
		instr_shifted = {hwbuf, hwbuf, cir[31:16]};
	end else begin
		instr_shifted = {hwbuf, cir};
	end
end

// lay the new word over the first free halfword
always_comb begin
	if (cir_lock || (level_no_fetch[1] && !unaligned_jump_dph)) begin
		instr_next = instr_shifted;
	end else if (unaligned_jump_dph && EXTENSION_C) begin
		instr_next = {instr_shifted[47:16], fetch_data[31:16]};
	end else if (level_no_fetch[0] && EXTENSION_C) begin
		instr_next = {fetch_data, instr_shifted[15:0]};
	end else begin
		instr_next = {instr_shifted[47:32], fetch_data};
	end
end

assign cir_must_refill = !cir_lock && !level_no_fetch[1];
assign fifo_pop        = cir_must_refill && !fifo_empty;

always_comb begin
	if (jump_now || flush_count != 2'd0 || cir_lock) begin
		buf_level_next = 2'd0;
	end else if (fetch_data_vld && unaligned_jump_dph) begin
		buf_level_next = 2'd1;
	end else begin
		buf_level_next = buf_level + {cir_must_refill && fetch_data_vld, 1'b0}
			- cir_use_clipped;
	end
end

// cir_vld saturates at 2 since hwbuf is not visible to decode
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		buf_level <= 2'd0;
		cir_vld   <= 2'd0;
	end else begin
		buf_level <= buf_level_next;
		if (!cir_lock) begin
			cir_vld <= buf_level_next & ~(buf_level_next >> 1);
		end
	end
end

always_ff @(posedge clk) begin
	{hwbuf, cir} <= instr_next;
end

endmodule

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// ==================================================
	// fetch side definitions
	// ==================================================

	// number of valid halfwords in cir, from 0 up to 2
	typedef logic [1:0] cir_level_t;

	// the front end starts fetching here when reset is released
	parameter bus_pkg::addr_t RESET_VECTOR = 32'h0000_0000;

endpackage

`default_nettype wire

//--- src/fetch_subsys_top.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_subsys_top #(
	parameter int FIFO_DEPTH  = 2,
	parameter bit EXTENSION_C = 1'b1,
	parameter int WAIT_CYCLES = 1,
	parameter int MEM_WORDS   = 256
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire bus_pkg::addr_t        jump_target,
	input  wire                        jump_target_vld,
	output logic                       jump_target_rdy,
	output bus_pkg::word_t             cir,
	output fetch_pkg::cir_level_t      cir_vld,
	input  wire fetch_pkg::cir_level_t cir_use,
	input  wire                        cir_lock,
	input  wire bus_pkg::addr_t        ls_addr,
	input  wire                        ls_write,
	input  wire bus_pkg::word_t        ls_wdata,
	input  wire                        ls_vld,
	output logic                       ls_rdy,
	output bus_pkg::word_t             ls_rdata,
	output logic                       ls_rdata_vld
);
	import bus_pkg::*;

// ==================================================
// interconnect
// ==================================================

// fetch peer to arbiter
addr_t fetch_addr;
logic  fetch_addr_vld;
logic  fetch_addr_rdy;
logic  fetch_data_vld;

// load/store peer to arbiter
addr_t lsu_addr;
logic  lsu_write;
word_t lsu_wdata;
logic  lsu_addr_vld;
logic  lsu_addr_rdy;
logic  lsu_data_vld;

// arbiter to SRAM, read data fans out to both peers
addr_t bus_addr;
logic  bus_write;
word_t bus_wdata;
logic  bus_addr_vld;
logic  bus_addr_rdy;
word_t bus_rdata;
logic  bus_data_vld;

// reads are always whole words, so the fetch size is left open
fetch_frontend #(
	.FIFO_DEPTH  (FIFO_DEPTH),
	.EXTENSION_C (EXTENSION_C)
) u_frontend (
	.clk             (clk),
	.rst_n           (rst_n),
	.mem_addr        (fetch_addr),
	.mem_size        (),
	.mem_addr_vld    (fetch_addr_vld),
	.mem_addr_rdy    (fetch_addr_rdy),
	.mem_data        (bus_rdata),
	.mem_data_vld    (fetch_data_vld),
	.jump_target     (jump_target),
	.jump_target_vld (jump_target_vld),
	.jump_target_rdy (jump_target_rdy),
	.cir             (cir),
	.cir_vld         (cir_vld),
	.cir_use         (cir_use),
	.cir_lock        (cir_lock)
);

load_store_unit u_lsu (
	.clk          (clk),
	.rst_n        (rst_n),
	.ls_addr      (ls_addr),
	.ls_write     (ls_write),
	.ls_wdata     (ls_wdata),
	.ls_vld       (ls_vld),
	.ls_rdy       (ls_rdy),
	.ls_rdata     (ls_rdata),
	.ls_rdata_vld (ls_rdata_vld),
	.mem_addr     (lsu_addr),
	.mem_write    (lsu_write),
	.mem_wdata    (lsu_wdata),
	.mem_addr_vld (lsu_addr_vld),
	.mem_addr_rdy (lsu_addr_rdy),
	.mem_data     (bus_rdata),
	.mem_data_vld (lsu_data_vld)
);

mem_arbiter u_arbiter (
	.clk            (clk),
	.rst_n          (rst_n),
	.fetch_addr     (fetch_addr),
	.fetch_addr_vld (fetch_addr_vld),
	.fetch_addr_rdy (fetch_addr_rdy),
	.fetch_data_vld (fetch_data_vld),
	.ls_addr        (lsu_addr),
	.ls_write       (lsu_write),
	.ls_wdata       (lsu_wdata),
	.ls_addr_vld    (lsu_addr_vld),
	.ls_addr_rdy    (lsu_addr_rdy),
	.ls_data_vld    (lsu_data_vld),
	.bus_addr       (bus_addr),
	.bus_write      (bus_write),
	.bus_wdata      (bus_wdata),
	.bus_addr_vld   (bus_addr_vld),
	.bus_addr_rdy   (bus_addr_rdy),
	.bus_data_vld   (bus_data_vld)
);

sram_model #(
	.WAIT_CYCLES (WAIT_CYCLES),
	.MEM_WORDS   (MEM_WORDS)
) u_sram (
	.clk      (clk),
	.rst_n    (rst_n),
	.addr     (bus_addr),
	.write    (bus_write),
	.wdata    (bus_wdata),
	.addr_vld (bus_addr_vld),
	.addr_rdy (bus_addr_rdy),
	.rdata    (bus_rdata),
	.data_vld (bus_data_vld)
);

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
`default_nettype none
`timescale 1ns/1ns

module load_store_unit (
	input  wire                 clk,
	input  wire                 rst_n,
	// request side, one access at a time
	input  wire bus_pkg::addr_t ls_addr,
	input  wire                 ls_write,
	input  wire bus_pkg::word_t ls_wdata,
	input  wire                 ls_vld,
	output logic                ls_rdy,
	output bus_pkg::word_t      ls_rdata,
	output logic                ls_rdata_vld,
	// bus master side
	output bus_pkg::addr_t      mem_addr,
	output logic                mem_write,
	output bus_pkg::word_t      mem_wdata,
	output logic                mem_addr_vld,
	input  wire                 mem_addr_rdy,
	input  wire bus_pkg::word_t mem_data,
	input  wire                 mem_data_vld
);
	import bus_pkg::*;

typedef enum logic [1:0] {
	ls_idle,
	ls_addr_ph,
	ls_data
} ls_state_t;

ls_state_t state;
addr_t     addr_q;
logic      write_q;
word_t     wdata_q;

// the bus sees only the registered copy, so it stays stable while held
assign ls_rdy       = state == ls_idle;
assign mem_addr     = addr_q;
assign mem_write    = write_q;
assign mem_wdata    = wdata_q;
assign mem_addr_vld = state == ls_addr_ph;

// a store finishes with the same pulse as a load, as its acknowledge
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state        <= ls_idle;
		ls_rdata_vld <= 1'b0;
	end else begin
		ls_rdata_vld <= 1'b0;
		case (state)
			ls_idle: begin
				if (ls_vld) begin
					state <= ls_addr_ph;
				end
			end
			ls_addr_ph: begin
				if (mem_addr_rdy) begin
					state <= ls_data;
				end
			end
			ls_data: begin
				if (mem_data_vld) begin
					state        <= ls_idle;
					ls_rdata_vld <= 1'b1;
				end
			end
			default: state <= ls_idle;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (ls_rdy && ls_vld) begin
		addr_q  <= ls_addr;
		write_q <= ls_write;
		wdata_q <= ls_wdata;
	end
	if (state == ls_data && mem_data_vld && !write_q) begin
		ls_rdata <= mem_data;
	end
end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module mem_arbiter (
	input  wire                 clk,
	input  wire                 rst_n,
	// fetch peer, reads only
	input  wire bus_pkg::addr_t fetch_addr,
	input  wire                 fetch_addr_vld,
	output logic                fetch_addr_rdy,
	output logic                fetch_data_vld,
	// load/store peer
	input  wire bus_pkg::addr_t ls_addr,
	input  wire                 ls_write,
	input  wire bus_pkg::word_t ls_wdata,
	input  wire                 ls_addr_vld,
	output logic                ls_addr_rdy,
	output logic                ls_data_vld,
	// towards the SRAM
	output bus_pkg::addr_t      bus_addr,
	output logic                bus_write,
	output bus_pkg::word_t      bus_wdata,
	output logic                bus_addr_vld,
	input  wire                 bus_addr_rdy,
	input  wire                 bus_data_vld
);
	import bus_pkg::*;

owner_t     grant;
logic       hold_vld;
owner_t     hold_owner;
owner_t     owner_q [2];
logic [1:0] owner_count;
logic       push;
logic       pop;

// ==================================================
// address phase
// ==================================================

// a request left waiting keeps its grant, otherwise load/store goes first
always_comb begin
	if (hold_vld) begin
		grant = hold_owner;
	end else if (ls_addr_vld) begin
		grant = owner_ls;
	end else begin
		grant = owner_fetch;
	end
end

assign bus_addr       = grant == owner_ls ? ls_addr : fetch_addr;
assign bus_write      = grant == owner_ls && ls_write;
assign bus_wdata      = ls_wdata;
assign bus_addr_vld   = grant == owner_ls ? ls_addr_vld : fetch_addr_vld;
assign fetch_addr_rdy = grant == owner_fetch && bus_addr_rdy;
assign ls_addr_rdy    = grant == owner_ls && bus_addr_rdy;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		hold_vld   <= 1'b0;
		hold_owner <= owner_fetch;
	end else begin
		hold_vld   <= bus_addr_vld && !bus_addr_rdy;
		hold_owner <= grant;
	end
end

// ==================================================
// data phase routing
// ==================================================

assign push = bus_addr_vld && bus_addr_rdy;
assign pop  = bus_data_vld;

// returns come back in order, so the head names the current owner
assign fetch_data_vld = pop && owner_q[0] == owner_fetch;
assign ls_data_vld    = pop && owner_q[0] == owner_ls;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		owner_count <= 2'd0;
	end else begin
		owner_count <= owner_count + 2'(push) - 2'(pop);
	end
end

// a push in the same cycle as a pop lands one slot lower
always_ff @(posedge clk) begin
	if (pop) begin
		owner_q[0] <= owner_q[1];
	end
	if (push) begin
		owner_q[1'(owner_count - 2'(pop))] <= grant;
	end
end

endmodule

`default_nettype wire

//--- src/sram_model.sv
`default_nettype none
`timescale 1ns/1ns

module sram_model #(
	parameter int WAIT_CYCLES = 1,
	parameter int MEM_WORDS   = 256
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire bus_pkg::addr_t addr,
	input  wire                 write,
	input  wire bus_pkg::word_t wdata,
	input  wire                 addr_vld,
	output logic                addr_rdy,
	output bus_pkg::word_t      rdata,
	output logic                data_vld
);
	import bus_pkg::*;

localparam int IDX_W = $clog2(MEM_WORDS);

word_t            mem [MEM_WORDS];
logic             busy;
logic [1:0]       wait_cnt;
addr_t            addr_q;
logic             write_q;
word_t            wdata_q;
logic             accept;
logic             access;
logic [IDX_W-1:0] idx;
logic             access_write;
word_t            access_wdata;

// ready again in the cycle data goes back, so the next request overlaps it
assign addr_rdy = !busy || wait_cnt == 2'd0;
assign accept   = addr_vld && addr_rdy;

// the array is accessed on the edge that starts the data cycle; with no
// wait states that is the accepting edge itself
always_comb begin
	if (WAIT_CYCLES == 0) begin
		access       = accept;
		idx          = addr[IDX_W+1:2];
		access_write = write;
		access_wdata = wdata;
	end else begin
		access       = busy && wait_cnt == 2'd1;
		idx          = addr_q[IDX_W+1:2];
		access_write = write_q;
		access_wdata = wdata_q;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		busy     <= 1'b0;
		wait_cnt <= 2'd0;
		data_vld <= 1'b0;
	end else begin
		data_vld <= access;
		if (accept) begin
			busy     <= 1'b1;
			wait_cnt <= 2'(WAIT_CYCLES);
		end else if (busy && wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end else begin
			busy <= 1'b0;
		end
	end
end

// a write returns the old word, which the master ignores
always_ff @(posedge clk) begin
	if (accept) begin
		addr_q  <= addr;
		write_q <= write;
		wdata_q <= wdata;
	end
	if (access) begin
		if (access_write) begin
			mem[idx] <= access_wdata;
		end
		rdata <= mem[idx];
	end
end

endmodule

`default_nettype wire

//--- verification/fetch_subsys_chk.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_subsys_chk (
	input wire                        clk,
	input wire                        rst_n,
	// front end side
	input wire [1:0]                  fetches_in_flight,
	input wire fetch_pkg::cir_level_t cir_vld,
	input wire fetch_pkg::cir_level_t cir_use,
	// arbiter owner queue
	input wire [1:0]                  owner_count,
	input wire                        owner_push,
	input wire                        owner_pop
);

// running count of failed properties in this instance
int failures = 0;

// ==================================================
// front end protocol
// ==================================================

// requests offered but not yet returned, held ones included
a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
	fetches_in_flight <= 2'd2)
	else begin
		$error("more than two fetches in flight");
		failures++;
	end

// decode may only take halfwords that cir actually holds
a_cir_use: assert property (@(posedge clk) disable iff (!rst_n)
	cir_use <= cir_vld)
	else begin
		$error("decode consumed more halfwords than cir holds");
		failures++;
	end

// ==================================================
// arbiter owner queue
// ==================================================

a_owner_overflow: assert property (@(posedge clk) disable iff (!rst_n)
	owner_push && !owner_pop |-> owner_count < 2'd2)
	else begin
		$error("owner queue pushed while full");
		failures++;
	end

// every returning data phase needs an owner waiting for it
a_owner_underflow: assert property (@(posedge clk) disable iff (!rst_n)
	owner_pop |-> owner_count != 2'd0)
	else begin
		$error("bus data returned with an empty owner queue");
		failures++;
	end

endmodule

// one instance sees the front end counter and the arbiter owner queue together
bind fetch_subsys_top fetch_subsys_chk u_chk (
	.clk               (clk),
	.rst_n             (rst_n),
	.fetches_in_flight (u_frontend.pending_fetches),
	.cir_vld           (cir_vld),
	.cir_use           (cir_use),
	.owner_count       (u_arbiter.owner_count),
	.owner_push        (u_arbiter.push),
	.owner_pop         (u_arbiter.pop)
);

`default_nettype wire

//--- verification/tb_fetch_subsys.sv
`default_nettype none
`timescale 1ns/1ns

module tb_fetch_subsys;
	import bus_pkg::*;
	import fetch_pkg::*;

// ==================================================
// run length
// ==================================================

localparam int RESET_CYCLES  = 16;
localparam int LS_OPS        = 80;
localparam int HALFWORDS     = 95;
localparam int JUMPS         = 5;
localparam int LOCK_CYCLES   = 8;
// generous cost per item, doubled on top
localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 16 * LS_OPS + 4 * HALFWORDS
	+ 12 * JUMPS + LOCK_CYCLES);

localparam addr_t PROGRAM_BASE  = 32'h0000_0100;
localparam int    PROGRAM_WORDS = 64;

logic       clk;
logic       rst_n;
addr_t      jump_target;
logic       jump_target_vld;
logic       jump_target_rdy;
word_t      cir;
cir_level_t cir_vld;
cir_level_t cir_use;
logic       cir_lock;
addr_t      ls_addr;
logic       ls_write;
word_t      ls_wdata;
logic       ls_vld;
logic       ls_rdy;
word_t      ls_rdata;
logic       ls_rdata_vld;

// expected SRAM contents, updated by every store
word_t       model_mem [256];
logic [31:0] lfsr_state;
int          checks      = 0;
int          errors      = 0;
int          cycle_count = 0;

fetch_subsys_top dut (
	.clk             (clk),
	.rst_n           (rst_n),
	.jump_target     (jump_target),
	.jump_target_vld (jump_target_vld),
	.jump_target_rdy (jump_target_rdy),
	.cir             (cir),
	.cir_vld         (cir_vld),
	.cir_use         (cir_use),
	.cir_lock        (cir_lock),
	.ls_addr         (ls_addr),
	.ls_write        (ls_write),
	.ls_wdata        (ls_wdata),
	.ls_vld          (ls_vld),
	.ls_rdy          (ls_rdy),
	.ls_rdata        (ls_rdata),
	.ls_rdata_vld    (ls_rdata_vld)
);

always #20 clk = ~clk;

// ==================================================
// helpers
// ==================================================

// taps 32, 22, 2 and 1 give a maximal length sequence
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
endtask

// a halfword in memory order, odd halfwords are the upper half of a word
function automatic half_t model_half(input addr_t a);
	word_t w;
	w = model_mem[a[9:2]];
	return a[1] ? w[31:16] : w[15:0];
endfunction

function automatic int checker_failures();
	return dut.u_chk.failures;
endfunction

task automatic expect_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	checks++;
	assert (got === exp)
	else begin
		$display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
		errors++;
	end
endtask

task automatic report_counts();
	$display("checks: %0d, errors: %0d, assertion failures: %0d",
		checks, errors, checker_failures());
endtask

// every task below starts and ends just after a falling edge
task automatic lsu_access(input addr_t a, input logic wr, input word_t data,
	output word_t rdata);
	while (!ls_rdy) @(negedge clk);
	ls_addr  = a;
	ls_write = wr;
	ls_wdata = data;
	ls_vld   = 1'b1;
	@(negedge clk);
	ls_vld = 1'b0;
	// the request has left the idle state, so no second one is taken
	expect_value("ls_rdy", 32'(ls_rdy), 32'd0);
	// stores complete with the same pulse as loads
	while (!ls_rdata_vld) @(negedge clk);
	rdata = ls_rdata;
endtask

task automatic store_word(input addr_t a, input word_t data);
	word_t ack;
	lsu_access(a, 1'b1, data, ack);
	model_mem[a[9:2]] = data;
endtask

task automatic load_and_compare(input addr_t a);
	word_t got;
	lsu_access(a, 1'b0, '0, got);
	expect_value("ls_rdata", got, model_mem[a[9:2]]);
endtask

task automatic load_program();
	logic [31:0] r;
	for (int i = 0; i < PROGRAM_WORDS; i++) begin
		random_bits(32, r);
		store_word(PROGRAM_BASE + 32'(4 * i), r);
	end
endtask

// decode consumes nothing in the cycle that carries the jump
task automatic jump_to(input addr_t target, input logic lock);
	cir_use         = 2'd0;
	cir_lock        = lock;
	jump_target     = target;
	jump_target_vld = 1'b1;
	while (!jump_target_rdy) @(negedge clk);
	@(negedge clk);
	jump_target_vld = 1'b0;
endtask

// acts as decode, taking whole words (width 2) or single halfwords (width 1)
task automatic follow_stream(input addr_t start, input int count, input int width);
	addr_t a;
	int    n;
	a = start;
	n = 0;
	while (n < count) begin
		cir_use = 2'd0;
		if (width == 2 && cir_vld == 2'd2) begin
			expect_value("cir", cir, model_mem[a[9:2]]);
			cir_use = 2'd2;
			a += 32'd4;
			n++;
		end else if (width == 1 && cir_vld != 2'd0) begin
			expect_value("cir[15:0]", {16'h0, cir[15:0]}, {16'h0, model_half(a)});
			cir_use = 2'd1;
			a += 32'd2;
			n++;
		end
		@(negedge clk);
	end
	cir_use = 2'd0;
endtask

// ==================================================
// directed tests
// ==================================================

task automatic memory_roundtrip();
	addr_t       addrs [6];
	logic [31:0] r;
	@(negedge clk);
	// nothing may come out of the front end or the load/store port yet
	expect_value("cir_vld", 32'(cir_vld), 32'd0);
	expect_value("ls_rdata_vld", 32'(ls_rdata_vld), 32'd0);
	for (int i = 0; i < 6; i++) begin
		random_bits(8, r);
		addrs[i] = {22'd0, r[7:0], 2'b00};
		random_bits(32, r);
		store_word(addrs[i], r);
	end
	for (int i = 0; i < 6; i++) begin
		load_and_compare(addrs[i]);
	end
endtask

task automatic aligned_jump_stream();
	jump_to(32'h0000_0100, 1'b0);
	follow_stream(32'h0000_0100, 12, 2);
endtask

task automatic halfword_stepping();
	jump_to(32'h0000_0140, 1'b0);
	follow_stream(32'h0000_0140, 20, 1);
endtask

// the first halfword comes from the upper half of the aligned word
task automatic odd_halfword_target();
	jump_to(32'h0000_016a, 1'b0);
	follow_stream(32'h0000_016a, 15, 1);
endtask

task automatic jump_under_lock();
	word_t      frozen_cir;
	cir_level_t frozen_vld;
	frozen_cir = cir;
	frozen_vld = cir_vld;
	jump_to(32'h0000_0180, 1'b1);
	repeat (LOCK_CYCLES) begin
		expect_value("cir", cir, frozen_cir);
		expect_value("cir_vld", 32'(cir_vld), 32'(frozen_vld));
		@(negedge clk);
	end
	// cir_vld is still the frozen value in the release cycle
	cir_lock = 1'b0;
	@(negedge clk);
	follow_stream(32'h0000_0180, 12, 1);
endtask

task automatic loads_amid_fetch();
	jump_to(32'h0000_01a0, 1'b0);
	fork
		follow_stream(32'h0000_01a0, 24, 1);
		begin : data_loads
			logic [31:0] r;
			for (int i = 0; i < 4; i++) begin
				random_bits(6, r);
				load_and_compare(PROGRAM_BASE + {24'd0, r[5:0], 2'b00});
			end
		end
	join
endtask

// ==================================================
// run control
// ==================================================

always @(posedge clk) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= TIMEOUT_CYCLES) begin
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		report_counts();
		$display("Finished with errors");
		$finish;
	end
end

initial begin
	clk             = 1'b0;
	rst_n           = 1'b0;
	jump_target     = '0;
	jump_target_vld = 1'b0;
	cir_use         = 2'd0;
	cir_lock        = 1'b0;
	ls_addr         = '0;
	ls_write        = 1'b0;
	ls_wdata        = '0;
	ls_vld          = 1'b0;
	lfsr_state      = 32'hbf4c_3e5e;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;

	memory_roundtrip();
	load_program();
	aligned_jump_stream();
	halfword_stepping();
	odd_halfword_target();
	jump_under_lock();
	loads_amid_fetch();

	repeat (4) @(negedge clk);
	report_counts();
	if (errors == 0 && checker_failures() == 0) begin
		$display("Finished with no errors");
	end else begin
		$display("Finished with errors");
	end
	$finish;
end

endmodule

`default_nettype wire
